// ==== axis_write_master.sv ====
// AXI4-Stream to AXI4 write master, top level
// Start with ctrl_start plus address and size, wait for the ctrl_done pulse
`default_nettype none
`timescale 1ns/10ps

module axis_write_master #(
  parameter int ADDR_WIDTH      = 32,
  parameter int MAX_OUTSTANDING = 4
) (
  input  wire                            aclk,
  input  wire                            areset,
  // Control
  input  wire                            ctrl_start,
  input  wire  [ADDR_WIDTH-1:0]          ctrl_addr_offset,
  input  wire  wr_master_pkg::xfer_size_t ctrl_xfer_size,
  output logic                           ctrl_done,
  // Stream input
  input  wire                            s_axis_tvalid,
  output logic                           s_axis_tready,
  input  wire  wr_master_pkg::data_t      s_axis_tdata,
  // Write address
  output logic                           m_axi_awvalid,
  input  wire                            m_axi_awready,
  output logic [ADDR_WIDTH-1:0]          m_axi_awaddr,
  output wr_master_pkg::axi_len_t        m_axi_awlen,
  // Write data
  output logic                           m_axi_wvalid,
  input  wire                            m_axi_wready,
  output wr_master_pkg::data_t           m_axi_wdata,
  output wr_master_pkg::strb_t           m_axi_wstrb,
  output logic                           m_axi_wlast,
  // Write response
  input  wire                            m_axi_bvalid,
  output logic                           m_axi_bready
);

  logic [ADDR_WIDTH-1:0]   base_addr;
  logic                    xfer_start;
  wr_master_pkg::txn_cnt_t num_txns;
  wr_master_pkg::axi_len_t final_len;
  logic                    single_txn;
  wr_master_pkg::strb_t    final_strb;
  logic                    w_first_pulse;
  logic                    aw_accept;
  logic                    aw_stall;

  wr_xfer_setup #(.ADDR_WIDTH(ADDR_WIDTH)) u_setup (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .base_addr        (base_addr),
    .xfer_start       (xfer_start),
    .num_txns         (num_txns),
    .final_len        (final_len),
    .single_txn       (single_txn),
    .final_strb       (final_strb)
  );

  // Data path, first beats trigger addresses
  wr_data_channel u_data (
    .aclk          (aclk),
    .areset        (areset),
    .xfer_start    (xfer_start),
    .num_txns      (num_txns),
    .final_len     (final_len),
    .single_txn    (single_txn),
    .final_strb    (final_strb),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tdata  (s_axis_tdata),
    .m_axi_wready  (m_axi_wready),
    .s_axis_tready (s_axis_tready),
    .m_axi_wvalid  (m_axi_wvalid),
    .m_axi_wdata   (m_axi_wdata),
    .m_axi_wstrb   (m_axi_wstrb),
    .m_axi_wlast   (m_axi_wlast),
    .w_first_pulse (w_first_pulse)
  );

  wr_addr_channel #(.ADDR_WIDTH(ADDR_WIDTH)) u_addr (
    .aclk          (aclk),
    .areset        (areset),
    .base_addr     (base_addr),
    .xfer_start    (xfer_start),
    .num_txns      (num_txns),
    .final_len     (final_len),
    .single_txn    (single_txn),
    .w_first_pulse (w_first_pulse),
    .aw_stall      (aw_stall),
    .m_axi_awready (m_axi_awready),
    .m_axi_awvalid (m_axi_awvalid),
    .m_axi_awaddr  (m_axi_awaddr),
    .m_axi_awlen   (m_axi_awlen),
    .aw_accept     (aw_accept)
  );

  // Response side closes the loop on outstanding bursts
  wr_resp_tracker #(.MAX_OUTSTANDING(MAX_OUTSTANDING)) u_resp (
    .aclk         (aclk),
    .areset       (areset),
    .xfer_start   (xfer_start),
    .num_txns     (num_txns),
    .aw_accept    (aw_accept),
    .m_axi_bvalid (m_axi_bvalid),
    .m_axi_bready (m_axi_bready),
    .aw_stall     (aw_stall),
    .ctrl_done    (ctrl_done)
  );

endmodule

`default_nettype wire

// ==== files.f ====
wr_master_pkg.sv
wr_updown_counter.sv
wr_xfer_setup.sv
wr_data_channel.sv
wr_addr_channel.sv
wr_resp_tracker.sv
axis_write_master.sv
tb_clock_gen.sv
tb_write_master.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the write master testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_write_master -f files.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Build failed"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

// ==== tb_clock_gen.sv ====
// Testbench clock and reset source for the write master
// 8 ns clock, reset held high for the first five cycles
`default_nettype none
`timescale 1ns/10ps

module tb_clock_gen (
  output logic aclk,
  output logic areset
);

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  // Release on a falling edge, same as the other stimulus
  initial begin
    areset = 1'b1;
    repeat (5) @(posedge aclk);
    @(negedge aclk);
    areset = 1'b0;
  end

endmodule

`default_nettype wire

// ==== tb_write_master.sv ====
// Directed testbench for the stream-to-AXI write master
// Holds an AXI slave model, an LFSR for back-pressure and one task per test
`default_nettype none
`timescale 1ns/10ps

module tb_write_master;

  // Beats over all tests, sets the watchdog budget
  localparam int TOTAL_BEATS = 10 + 4 + 650 + 1250;

  logic        aclk;
  logic        areset;
  logic        ctrl_start = 1'b0;
  logic [31:0] ctrl_addr_offset = '0;
  logic [19:0] ctrl_xfer_size = '0;
  logic        ctrl_done;
  logic        s_axis_tvalid = 1'b0;
  logic        s_axis_tready;
  logic [31:0] s_axis_tdata = '0;
  logic        m_axi_awvalid;
  logic        m_axi_awready = 1'b1;
  logic [31:0] m_axi_awaddr;
  logic [7:0]  m_axi_awlen;
  logic        m_axi_wvalid;
  logic        m_axi_wready = 1'b1;
  logic [31:0] m_axi_wdata;
  logic [3:0]  m_axi_wstrb;
  logic        m_axi_wlast;
  logic        m_axi_bvalid = 1'b0;
  logic        m_axi_bready;

  // Slave model records
  logic [31:0] aw_addr_q[$];
  logic [7:0]  aw_len_q[$];
  logic [31:0] w_data_q[$];
  logic [3:0]  w_strb_q[$];
  logic        w_last_q[$];
  int          aw_cnt = 0;
  int          wlast_cnt = 0;
  int          b_cnt = 0;
  int          done_cnt = 0;
  int          done_seen_b = 0;
  int          resp_sent = 0;
  int          resp_wait = 0;

  // Stimulus state
  logic [31:0] lfsr_state = 32'h5f0e_7f16;
  logic [31:0] stream_word = '0;
  logic        t_fire = 1'b0;
  logic        stream_on = 1'b0;
  logic        rand_mode = 1'b0;
  logic        hold_resp = 1'b0;

  tb_clock_gen u_clk (
    .aclk   (aclk),
    .areset (areset)
  );

  axis_write_master #(.ADDR_WIDTH(32), .MAX_OUTSTANDING(4)) UUT (
    .aclk             (aclk),
    .areset           (areset),
    .ctrl_start       (ctrl_start),
    .ctrl_addr_offset (ctrl_addr_offset),
    .ctrl_xfer_size   (ctrl_xfer_size),
    .ctrl_done        (ctrl_done),
    .s_axis_tvalid    (s_axis_tvalid),
    .s_axis_tready    (s_axis_tready),
    .s_axis_tdata     (s_axis_tdata),
    .m_axi_awvalid    (m_axi_awvalid),
    .m_axi_awready    (m_axi_awready),
    .m_axi_awaddr     (m_axi_awaddr),
    .m_axi_awlen      (m_axi_awlen),
    .m_axi_wvalid     (m_axi_wvalid),
    .m_axi_wready     (m_axi_wready),
    .m_axi_wdata      (m_axi_wdata),
    .m_axi_wstrb      (m_axi_wstrb),
    .m_axi_wlast      (m_axi_wlast),
    .m_axi_bvalid     (m_axi_bvalid),
    .m_axi_bready     (m_axi_bready)
  );

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic rand_bit();
    lfsr_state = {lfsr_state[30:0],
                  lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
    return lfsr_state[0];
  endfunction

  function automatic int rand_bits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(rand_bit());
    end
    return v;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Slave model and stream source
  //////////////////////////////////////////////////////////////////////

  // Sample every channel on the rising edge
  always @(posedge aclk) begin
    t_fire = s_axis_tvalid && s_axis_tready;
    if (m_axi_awvalid && m_axi_awready) begin
      aw_addr_q.push_back(m_axi_awaddr);
      aw_len_q.push_back(m_axi_awlen);
      aw_cnt++;
    end
    if (m_axi_wvalid && m_axi_wready) begin
      w_data_q.push_back(m_axi_wdata);
      w_strb_q.push_back(m_axi_wstrb);
      w_last_q.push_back(m_axi_wlast);
      if (m_axi_wlast) wlast_cnt++;
    end
    if (m_axi_bvalid && m_axi_bready) b_cnt++;
    if (ctrl_done) begin
      done_cnt++;
      done_seen_b = b_cnt;
    end
    if (aw_cnt - b_cnt > 4) fail_run("More than four bursts were outstanding");
  end

  // Ready, valid and response drive, tvalid holds until its beat is taken
  always @(negedge aclk) begin
    logic held;
    held = s_axis_tvalid && !t_fire;
    if (t_fire) stream_word = stream_word + 1;
    if (rand_mode) begin
      m_axi_awready = rand_bit();
      m_axi_wready  = rand_bit();
      if (!held) s_axis_tvalid = rand_bit();
    end else begin
      m_axi_awready = 1'b1;
      m_axi_wready  = 1'b1;
      s_axis_tvalid = stream_on;
    end
    s_axis_tdata = stream_word;
    // In-order responses once a burst has both address and last beat
    if (m_axi_bvalid) begin
      m_axi_bvalid = 1'b0;
    end else if (!hold_resp && resp_sent < aw_cnt && resp_sent < wlast_cnt) begin
      if (resp_wait == 0) begin
        m_axi_bvalid = 1'b1;
        resp_sent++;
        resp_wait = rand_bits(3);
      end else begin
        resp_wait--;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Transfer tasks
  //////////////////////////////////////////////////////////////////////

  task automatic begin_transfer(input logic [31:0] addr, input logic [19:0] size,
                                output logic [31:0] word0, output int done0,
                                output int b0);
    aw_addr_q.delete();
    aw_len_q.delete();
    w_data_q.delete();
    w_strb_q.delete();
    w_last_q.delete();
    word0 = stream_word;
    done0 = done_cnt;
    b0    = b_cnt;
    @(negedge aclk);
    ctrl_start       = 1'b1;
    ctrl_addr_offset = addr;
    ctrl_xfer_size   = size;
    @(negedge aclk);
    ctrl_start = 1'b0;
  endtask

  // Expected bursts, lengths and strobes from the byte count
  task automatic finish_transfer(input logic [31:0] addr, input int size,
                                 input logic [31:0] word0, input int done0, input int b0);
    int          beats;
    int          bursts;
    logic [31:0] base;
    logic [3:0]  last_strb;
    logic [7:0]  exp_len;
    beats     = (size + 3) / 4;
    bursts    = (beats + 255) / 256;
    base      = addr & ~32'h3ff;
    last_strb = (size % 4 == 0) ? 4'hf : 4'((1 << (size % 4)) - 1);
    while (done_cnt == done0) @(negedge aclk);
    repeat (20) @(negedge aclk);
    check_value("ctrl_done pulses", 32'(done_cnt - done0), 32'd1);
    check_value("responses before ctrl_done", 32'(done_seen_b - b0), 32'(bursts));
    check_value("address count", 32'(aw_addr_q.size()), 32'(bursts));
    check_value("beat count", 32'(w_data_q.size()), 32'(beats));
    for (int i = 0; i < bursts; i++) begin
      exp_len = (i == bursts - 1) ? 8'(beats - 1 - 256 * (bursts - 1)) : 8'd255;
      check_value("m_axi_awaddr", aw_addr_q[i], base + 32'(i * 1024));
      check_value("m_axi_awlen", 32'(aw_len_q[i]), 32'(exp_len));
    end
    for (int k = 0; k < beats; k++) begin
      check_value("m_axi_wdata", w_data_q[k], word0 + 32'(k));
      check_value("m_axi_wlast", 32'(w_last_q[k]),
                  32'((k % 256 == 255) || (k == beats - 1)));
      check_value("m_axi_wstrb", 32'(w_strb_q[k]),
                  32'((k == beats - 1) ? last_strb : 4'hf));
    end
  endtask

  task automatic run_transfer(input logic [31:0] addr, input int size);
    logic [31:0] word0;
    int          done0;
    int          b0;
    begin_transfer(addr, 20'(size), word0, done0, b0);
    finish_transfer(addr, size, word0, done0, b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  // Stream offered before any start must not leak through
  task automatic test_idle_outputs();
    stream_on = 1'b1;
    repeat (12) begin
      @(negedge aclk);
      check_value("m_axi_awvalid", 32'(m_axi_awvalid), 32'd0);
      check_value("m_axi_wvalid", 32'(m_axi_wvalid), 32'd0);
      check_value("s_axis_tready", 32'(s_axis_tready), 32'd0);
      check_value("ctrl_done", 32'(ctrl_done), 32'd0);
      check_value("m_axi_bready", 32'(m_axi_bready), 32'd1);
    end
  endtask

  task automatic test_single_burst();
    run_transfer(32'h1000, 40);
  endtask

  task automatic test_partial_strobe();
    run_transfer(32'h2345, 13);
  endtask

  task automatic test_multi_burst();
    run_transfer(32'h8000, 2600);
  endtask

  // Responses held until all data is in, so the address side hits the limit
  task automatic test_random_backpressure();
    logic [31:0] word0;
    int          done0;
    int          b0;
    int          last0;
    last0     = wlast_cnt;
    rand_mode = 1'b1;
    hold_resp = 1'b1;
    begin_transfer(32'h20000, 20'd5000, word0, done0, b0);
    while (wlast_cnt < last0 + 5) @(negedge aclk);
    repeat (20) @(negedge aclk);
    check_value("outstanding bursts", 32'(aw_cnt - b_cnt), 32'd4);
    hold_resp = 1'b0;
    finish_transfer(32'h20000, 5000, word0, done0, b0);
    rand_mode = 1'b0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    @(negedge areset);
    @(negedge aclk);
    test_idle_outputs();
    test_single_burst();
    test_partial_strobe();
    test_multi_burst();
    test_random_backpressure();
    $display("STATUS: PASS");
    $finish;
  end

  initial begin
    #(TOTAL_BEATS * 20 * 8);
    $display("Timeout, the tests did not finish in time");
    $display("STATUS: FAIL");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// ==== wr_addr_channel.sv ====
// Issues one burst address per first beat seen on the data channel
// Holds back while the response tracker reports the outstanding limit
`default_nettype none
`timescale 1ns/10ps

module wr_addr_channel #(
  parameter int ADDR_WIDTH = 32
) (
  input  wire                          aclk,
  input  wire                          areset,
  input  wire  [ADDR_WIDTH-1:0]        base_addr,
  input  wire                          xfer_start,
  input  wire  wr_master_pkg::txn_cnt_t num_txns,
  input  wire  wr_master_pkg::axi_len_t final_len,
  input  wire                          single_txn,
  input  wire                          w_first_pulse,
  input  wire                          aw_stall,
  input  wire                          m_axi_awready,
  output logic                         m_axi_awvalid,
  output logic [ADDR_WIDTH-1:0]        m_axi_awaddr,
  output wr_master_pkg::axi_len_t      m_axi_awlen,
  output logic                         aw_accept
);

  localparam int PEND_W = 8;
  localparam int TXN_W  = $bits(wr_master_pkg::txn_cnt_t);

  logic idle_aw;
  logic aw_final_txn;

  assign aw_accept = m_axi_awvalid & m_axi_awready;

  // Raise when a first beat waits and a slot is free, drop on accept
  always_ff @(posedge aclk) begin
    if (areset) begin
      m_axi_awvalid <= 1'b0;
    end else if (!idle_aw && !m_axi_awvalid && !aw_stall) begin
      m_axi_awvalid <= 1'b1;
    end else if (m_axi_awready) begin
      m_axi_awvalid <= 1'b0;
    end
  end

  // Burst address walks up one granule per accept
  always_ff @(posedge aclk) begin
    if (xfer_start) begin
      m_axi_awaddr <= base_addr;
    end else if (aw_accept) begin
      m_axi_awaddr <= m_axi_awaddr + ADDR_WIDTH'(wr_master_pkg::BURST_BYTES);
    end
  end

  // Short length only for the closing burst
  assign m_axi_awlen = (aw_final_txn || (xfer_start && single_txn))
                       ? final_len
                       : wr_master_pkg::axi_len_t'(wr_master_pkg::BURST_BEATS - 1);

  // First beats offered but not yet matched by an address
  wr_updown_counter #(.WIDTH(PEND_W), .INIT('0)) u_pending_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (w_first_pulse),
    .decr       (aw_accept),
    .load_value ('0),
    .count      (),
    .is_zero    (idle_aw)
  );

  // Addresses left to issue after the current one
  wr_updown_counter #(.WIDTH(TXN_W), .INIT('0)) u_aw_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (xfer_start),
    .incr       (1'b0),
    .decr       (aw_accept & ~aw_final_txn),
    .load_value (num_txns),
    .count      (),
    .is_zero    (aw_final_txn)
  );

  // Address payload holds until the slave takes it
  a_aw_stable: assert property (
    @(posedge aclk) disable iff (areset)
    (m_axi_awvalid && !m_axi_awready) |=>
      (m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen))
  );

endmodule

`default_nettype wire

// ==== wr_data_channel.sv ====
// Passes the stream onto the AXI write data channel while a transfer runs
// Generates wlast, wstrb and a pulse per burst first beat for the address engine
`default_nettype none
`timescale 1ns/10ps

module wr_data_channel (
  input  wire                          aclk,
  input  wire                          areset,
  input  wire                          xfer_start,
  input  wire  wr_master_pkg::txn_cnt_t num_txns,
  input  wire  wr_master_pkg::axi_len_t final_len,
  input  wire                          single_txn,
  input  wire  wr_master_pkg::strb_t    final_strb,
  input  wire                          s_axis_tvalid,
  input  wire  wr_master_pkg::data_t    s_axis_tdata,
  input  wire                          m_axi_wready,
  output logic                         s_axis_tready,
  output logic                         m_axi_wvalid,
  output wr_master_pkg::data_t         m_axi_wdata,
  output wr_master_pkg::strb_t         m_axi_wstrb,
  output logic                         m_axi_wlast,
  output logic                         w_first_pulse
);

  localparam int LEN_W = $bits(wr_master_pkg::axi_len_t);
  localparam int TXN_W = $bits(wr_master_pkg::txn_cnt_t);

  logic                    running;
  logic                    wxfer;
  logic                    burst_end;
  logic                    final_beat;
  logic                    w_final_txn;
  logic                    w_almost_final;
  logic                    beat_load;
  wr_master_pkg::axi_len_t beat_load_value;
  wr_master_pkg::txn_cnt_t txns_to_go;
  logic                    first_sent;
  logic                    first_offer;
  logic                    first_offer_d1;

  ///////////////////////////////////////////////////////////////////////
  // Stream gating
  ///////////////////////////////////////////////////////////////////////

  // No handshake before the size is known or after the last beat
  assign m_axi_wvalid  = s_axis_tvalid & running;
  assign m_axi_wdata   = s_axis_tdata;
  assign s_axis_tready = m_axi_wready & running;

  assign wxfer      = m_axi_wvalid & m_axi_wready;
  assign burst_end  = wxfer & m_axi_wlast;
  assign final_beat = burst_end & w_final_txn;

  always_ff @(posedge aclk) begin
    if (areset) begin
      running <= 1'b0;
    end else if (xfer_start) begin
      running <= 1'b1;
    end else if (final_beat) begin
      running <= 1'b0;
    end
  end

  ///////////////////////////////////////////////////////////////////////
  // Beat and burst countdowns
  ///////////////////////////////////////////////////////////////////////

  // Reload at start and at each burst end except the last
  assign beat_load       = xfer_start | (burst_end & ~w_final_txn);
  assign w_almost_final  = (txns_to_go == TXN_W'(1));
  assign beat_load_value = (xfer_start ? single_txn : w_almost_final)
                           ? final_len
                           : LEN_W'(wr_master_pkg::BURST_BEATS - 1);

  // Zero flag marks the last beat of the burst
  wr_updown_counter #(.WIDTH(LEN_W), .INIT('1)) u_beat_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (beat_load),
    .incr       (1'b0),
    .decr       (wxfer & ~m_axi_wlast),
    .load_value (beat_load_value),
    .count      (),
    .is_zero    (m_axi_wlast)
  );

  // Bursts left after the current one
  wr_updown_counter #(.WIDTH(TXN_W), .INIT('0)) u_burst_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (xfer_start),
    .incr       (1'b0),
    .decr       (burst_end & ~w_final_txn),
    .load_value (num_txns),
    .count      (txns_to_go),
    .is_zero    (w_final_txn)
  );

  // Only the very last beat may be partial
  assign m_axi_wstrb = (m_axi_wlast & w_final_txn) ? final_strb : '1;

  ///////////////////////////////////////////////////////////////////////
  // First-beat tracking
  ///////////////////////////////////////////////////////////////////////

  // One offer per burst, re-armed when the burst completes
  assign first_offer = m_axi_wvalid & ~first_sent;

  always_ff @(posedge aclk) begin
    if (areset) begin
      first_sent     <= 1'b0;
      first_offer_d1 <= 1'b0;
      w_first_pulse  <= 1'b0;
    end else begin
      if (burst_end) begin
        first_sent <= 1'b0;
      end else if (first_offer) begin
        first_sent <= 1'b1;
      end
      // Two cycles from the offer to the pulse
      first_offer_d1 <= first_offer;
      w_first_pulse  <= first_offer_d1;
    end
  end

  // Stream holds each offered beat until the slave takes it
  a_w_hold: assert property (
    @(posedge aclk) disable iff (areset)
    (m_axi_wvalid && !m_axi_wready) |=> (m_axi_wvalid && $stable(m_axi_wdata))
  );

endmodule

`default_nettype wire

// ==== wr_master_pkg.sv ====
// Protocol constants and vector types shared by the stream-to-AXI write master
// Referenced by scoped name from each engine and the top level
`default_nettype none

package wr_master_pkg;

  ///////////////////////////////////////////////////////////////////////
  // Protocol constants
  ///////////////////////////////////////////////////////////////////////

  // Bytes carried by one data beat
  localparam int unsigned DATA_BYTES = 4;

  // Longest burst, bounded by the 4 KiB rule and the 256-beat AXI4 limit
  localparam int unsigned BURST_BEATS =
      (4096 / DATA_BYTES < 256) ? 4096 / DATA_BYTES : 256;

  // Address step between bursts, also the alignment granule
  localparam int unsigned BURST_BYTES = DATA_BYTES * BURST_BEATS;

  ///////////////////////////////////////////////////////////////////////
  // Vector types
  ///////////////////////////////////////////////////////////////////////

  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;
  // Burst length as beats minus one
  typedef logic [7:0]  axi_len_t;
  // Transfer size in bytes
  typedef logic [19:0] xfer_size_t;
  // Burst count, size width less the 1 KiB burst granule
  typedef logic [9:0]  txn_cnt_t;

endpackage

`default_nettype wire

// ==== wr_resp_tracker.sv ====
// Counts write responses, limits bursts in flight and pulses done at the end
// The stall level goes back to the address engine
`default_nettype none
`timescale 1ns/10ps

module wr_resp_tracker #(
  parameter int MAX_OUTSTANDING = 4
) (
  input  wire                          aclk,
  input  wire                          areset,
  input  wire                          xfer_start,
  input  wire  wr_master_pkg::txn_cnt_t num_txns,
  input  wire                          aw_accept,
  input  wire                          m_axi_bvalid,
  output logic                         m_axi_bready,
  output logic                         aw_stall,
  output logic                         ctrl_done
);

  localparam int TXN_W = $bits(wr_master_pkg::txn_cnt_t);
  localparam int VAC_W = $clog2(MAX_OUTSTANDING + 1);

  logic             bxfer;
  logic             b_final_txn;
  logic [VAC_W-1:0] vacancy;

  // Responses are always taken
  assign m_axi_bready = 1'b1;
  assign bxfer        = m_axi_bvalid & m_axi_bready;

  // Done one cycle after the closing response
  always_ff @(posedge aclk) begin
    if (areset) begin
      ctrl_done <= 1'b0;
    end else begin
      ctrl_done <= bxfer & b_final_txn;
    end
  end

  // Responses still expected after the next one
  wr_updown_counter #(.WIDTH(TXN_W), .INIT('0)) u_resp_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (xfer_start),
    .incr       (1'b0),
    .decr       (bxfer & ~b_final_txn),
    .load_value (num_txns),
    .count      (),
    .is_zero    (b_final_txn)
  );

  // Free slots, each accept takes one and each response returns one
  wr_updown_counter #(.WIDTH(VAC_W), .INIT(VAC_W'(MAX_OUTSTANDING))) u_vacancy_cnt (
    .aclk       (aclk),
    .areset     (areset),
    .load       (1'b0),
    .incr       (bxfer),
    .decr       (aw_accept),
    .load_value ('0),
    .count      (vacancy),
    .is_zero    (aw_stall)
  );

  // A response must match an address already accepted
  a_resp_has_burst: assert property (
    @(posedge aclk) disable iff (areset)
    m_axi_bvalid |-> (vacancy != VAC_W'(MAX_OUTSTANDING))
  );

endmodule

`default_nettype wire

// ==== wr_updown_counter.sv ====
// Loadable up/down counter with a registered zero flag
// Shared by the data, address and response engines
`default_nettype none
`timescale 1ns/10ps

module wr_updown_counter #(
  parameter int               WIDTH = 8,
  parameter logic [WIDTH-1:0] INIT  = '0
) (
  input  wire              aclk,
  input  wire              areset,
  input  wire              load,
  input  wire              incr,
  input  wire              decr,
  input  wire [WIDTH-1:0]  load_value,
  output logic [WIDTH-1:0] count,
  output logic             is_zero
);

  // Load wins, incr and decr together leave the count alone
  always_ff @(posedge aclk) begin
    if (areset) begin
      count   <= INIT;
      is_zero <= (INIT == '0);
    end else if (load) begin
      count   <= load_value;
      is_zero <= (load_value == '0);
    end else if (incr && !decr) begin
      count   <= count + 1'b1;
      is_zero <= 1'b0;
    end else if (decr && !incr) begin
      count   <= count - 1'b1;
      // Zero next cycle when stepping down from one
      is_zero <= (count == WIDTH'(1));
    end
  end

  // Callers gate decr so the count never wraps below zero
  a_no_underflow: assert property (
    @(posedge aclk) disable iff (areset)
    (decr && !incr && !load) |-> !is_zero
  );

endmodule

`default_nettype wire

// ==== wr_xfer_setup.sv ====
// Captures a start request and derives burst count, final length and strobe
// Feeds the data, address and response engines through a delayed start pulse
`default_nettype none
`timescale 1ns/10ps

module wr_xfer_setup #(
  parameter int ADDR_WIDTH = 32
) (
  input  wire                           aclk,
  input  wire                           areset,
  input  wire                           ctrl_start,
  input  wire  [ADDR_WIDTH-1:0]         ctrl_addr_offset,
  input  wire  wr_master_pkg::xfer_size_t ctrl_xfer_size,
  output logic [ADDR_WIDTH-1:0]         base_addr,
  output logic                          xfer_start,
  output wr_master_pkg::txn_cnt_t       num_txns,
  output wr_master_pkg::axi_len_t       final_len,
  output logic                          single_txn,
  output wr_master_pkg::strb_t          final_strb
);

  // Byte lane bits, total beat width and burst length bits
  localparam int LANE_W  = $clog2(wr_master_pkg::DATA_BYTES);
  localparam int TOTAL_W = $bits(wr_master_pkg::xfer_size_t) - LANE_W;
  localparam int LEN_W   = $clog2(wr_master_pkg::BURST_BEATS);
  localparam logic [ADDR_WIDTH-1:0] ADDR_MASK = ADDR_WIDTH'(wr_master_pkg::BURST_BYTES - 1);

  logic [TOTAL_W-1:0] total_len_r;
  logic               start_d1;

  // Two-stage start delay so the derived fields settle first
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1   <= 1'b0;
      xfer_start <= 1'b0;
    end else begin
      start_d1   <= ctrl_start;
      xfer_start <= start_d1;
    end
  end

  // Sampled on the start pulse
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      // Round up to whole beats, kept as beats minus one
      total_len_r <= (ctrl_xfer_size[LANE_W-1:0] != '0)
                     ? ctrl_xfer_size[LANE_W +: TOTAL_W]
                     : ctrl_xfer_size[LANE_W +: TOTAL_W] - 1'b1;
      // Align down to the burst granule
      base_addr <= ctrl_addr_offset & ~ADDR_MASK;
      // Partial last beat keeps only the low lanes
      for (int i = 0; i < wr_master_pkg::DATA_BYTES; i++) begin
        final_strb[i] <= (ctrl_xfer_size[LANE_W-1:0] == '0) ||
                         (LANE_W'(i) < ctrl_xfer_size[LANE_W-1:0]);
      end
    end
  end

  // Upper bits count bursts, lower bits give the last burst length
  assign num_txns   = total_len_r[LEN_W +: $bits(wr_master_pkg::txn_cnt_t)];
  assign final_len  = total_len_r[0 +: $bits(wr_master_pkg::axi_len_t)];
  assign single_txn = (num_txns == '0);

endmodule

`default_nettype wire
